// ==== pma_unit.f ====
+incdir+.
pma_pkg.sv
pma_region_table.sv
pma_lookup_stage.sv
pma_check_stage.sv
pma_unit.sv
tb_pma_unit_assertions.sv
tb_pma_unit.sv

// ==== Makefile ====
# Verilator simulation of the PMA unit testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_pma_unit
FILELIST  ?= pma_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_pma_unit.sv ====
`timescale 1ns/1ps

`include "pma_defs.svh"

module tb_pma_unit;

  //////////////////////////////////////////////////
  // Run length and limit
  //////////////////////////////////////////////////

  localparam int STREAM_REQS = 200;
  // Requests per test: reset, priority, rules, attributes, debug, stream
  localparam int REQ_TOTAL = 6 + 18 + 10 + 6 + 8 + STREAM_REQS;
  // Table writes, the stream adds one every eighth cycle
  localparam int WR_TOTAL = 2 + 3 + 2 + STREAM_REQS / 8;
  localparam int TIMEOUT_CYCLES = 2 * (REQ_TOTAL + WR_TOTAL) + 100;

  // Qualifiers {debug, atomic, pushpop, misaligned, load, fetch}
  localparam logic [5:0] Q_STORE = 6'b000000;
  localparam logic [5:0] Q_FETCH = 6'b000001;
  localparam logic [5:0] Q_LOAD  = 6'b000010;
  localparam logic [5:0] Q_MIS   = 6'b000100;
  localparam logic [5:0] Q_PP    = 6'b001000;
  localparam logic [5:0] Q_ATOM  = 6'b010000;
  localparam logic [5:0] Q_DBG   = 6'b100000;

  // Compared result {id, err, integrity, bufferable, cacheable}
  typedef logic [`PMA_ID_W+3:0] result_t;

  logic                 clk;
  logic                 rst_i;
  logic                 cfg_we_i;
  pma_pkg::pma_idx_t    cfg_idx_i;
  logic [31:0]          cfg_addr_low_i;
  logic [31:0]          cfg_addr_high_i;
  logic                 cfg_main_i;
  logic                 cfg_bufferable_i;
  logic                 cfg_cacheable_i;
  logic                 cfg_integrity_i;
  logic                 cfg_atomic_i;
  logic                 trans_valid_i;
  logic [`PMA_ID_W-1:0] trans_id_i;
  logic [31:0]          trans_addr_i;
  logic                 trans_debug_region_i;
  logic                 trans_pushpop_i;
  logic                 instr_fetch_access_i;
  logic                 misaligned_access_i;
  logic                 load_access_i;
  logic                 atomic_access_i;
  logic                 pma_valid_o;
  logic [`PMA_ID_W-1:0] pma_id_o;
  logic                 pma_err_o;
  logic                 pma_integrity_o;
  logic                 pma_bufferable_o;
  logic                 pma_cacheable_o;

  // Mirror of the region table and the results still in flight
  pma_pkg::pma_cfg_t    mirror [`PMA_NUM_REGIONS];
  result_t              exp_q [$];
  result_t              head;
  logic [`PMA_ID_W-1:0] next_id;
  logic [31:0]          rng_state;
  int                   err_cnt;
  int                   check_cnt;
  int                   test_errs;
  int                   cycle_cnt;
  string                cur_test;

  pma_unit UUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt <= TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Regression failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Reference model and stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic result_t expected_result(input logic [31:0] addr, input logic [5:0] q,
                                              input logic [`PMA_ID_W-1:0] id);
    logic [31:0]       word;
    logic              hit;
    logic              err;
    pma_pkg::pma_cfg_t r;
    word = addr >> 2;
    hit  = 1'b0;
    r    = '0;
    // Lowest matching index wins, a miss leaves every attribute zero
    for (int i = 0; i < `PMA_NUM_REGIONS; i++) begin
      if (!hit && word >= mirror[i].word_addr_low && word < mirror[i].word_addr_high) begin
        hit = 1'b1;
        r   = mirror[i];
      end
    end
    // Debug region is plain main memory
    if (q[5]) begin
      r      = '0;
      r.main = 1'b1;
    end
    err = ((q[0] || q[2] || q[3]) && !r.main) || (`PMA_A_EXT != 0 && q[4] && !r.atomic);
    return {id, err, r.integrity, r.bufferable && !q[0] && !q[1], r.cacheable};
  endfunction

  // Request valid in the current cycle, expected result queued at once
  task automatic drive_request(input logic [31:0] addr, input logic [5:0] q);
    trans_valid_i        = 1'b1;
    trans_id_i           = next_id;
    trans_addr_i         = addr;
    instr_fetch_access_i = q[0];
    load_access_i        = q[1];
    misaligned_access_i  = q[2];
    trans_pushpop_i      = q[3];
    atomic_access_i      = q[4];
    trans_debug_region_i = q[5];
    exp_q.push_back(expected_result(addr, q, next_id));
    next_id = next_id + 1'b1;
  endtask

  // Attributes {main, bufferable, cacheable, integrity, atomic}
  task automatic write_region(input int idx, input logic [31:0] low, input logic [31:0] high,
                              input logic [4:0] attr);
    cfg_we_i        = 1'b1;
    cfg_idx_i       = pma_pkg::pma_idx_t'(idx);
    cfg_addr_low_i  = low;
    cfg_addr_high_i = high;
    {cfg_main_i, cfg_bufferable_i, cfg_cacheable_i, cfg_integrity_i, cfg_atomic_i} = attr;
    // Mirror changes after any request driven in this cycle
    if (idx < `PMA_NUM_REGIONS) begin
      mirror[idx] = {low, high, attr};
    end
  endtask

  task automatic next_cycle();
    @(negedge clk);
    trans_valid_i = 1'b0;
    cfg_we_i      = 1'b0;
  endtask

  task automatic send(input logic [31:0] addr, input logic [5:0] q);
    drive_request(addr, q);
    next_cycle();
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = err_cnt;
  endtask

  task automatic end_test();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    // One quiet cycle so no stray result leaks into the next test
    @(negedge clk);
    $display("%s finished, %0d errors", cur_test, err_cnt - test_errs);
  endtask

  // Outputs are sampled mid-cycle
  always @(negedge clk) begin
    if (!rst_i && pma_valid_o) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("%s: result with ID %0h came back with no request outstanding",
                 cur_test, pma_id_o);
      end else begin
        head = exp_q.pop_front();
        check_cnt++;
        if ({pma_id_o, pma_err_o, pma_integrity_o, pma_bufferable_o, pma_cacheable_o} !== head) begin
          err_cnt++;
          $display("Error %s: id/err/int/buf/cache expected %b actual %b", cur_test, head,
                   {pma_id_o, pma_err_o, pma_integrity_o, pma_bufferable_o, pma_cacheable_o});
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic reset_defaults();
    begin_test("reset_defaults");
    // Empty table, so every fetch hits the I/O default
    send(32'h0000_0000, Q_FETCH);
    send(32'h0000_1000, Q_FETCH);
    send(32'hFFFF_FFFC, Q_FETCH);
    send(rand32(), Q_FETCH);
    send(32'h0000_4004, Q_STORE);
    send(32'h8000_0000, Q_LOAD);
    end_test();
  endtask

  task automatic region_priority();
    logic [31:0] words [9];
    begin_test("region_priority");
    // Region 1 overlaps the top half of region 0
    write_region(0, 32'h100, 32'h200, 5'b11101);
    next_cycle();
    write_region(1, 32'h180, 32'h300, 5'b00010);
    next_cycle();
    words = '{32'h0FF, 32'h100, 32'h17F, 32'h180, 32'h1C0, 32'h1FF, 32'h200, 32'h2FF, 32'h300};
    for (int i = 0; i < 9; i++) begin
      // Byte offset bits must not move the match
      send({words[i][29:0], 2'(i)}, Q_STORE);
      send({words[i][29:0], 2'b00}, Q_FETCH);
    end
    end_test();
  endtask

  task automatic access_rules();
    logic [5:0] kinds [4];
    begin_test("access_rules");
    write_region(2, 32'h1000, 32'h1100, 5'b00000);
    next_cycle();
    write_region(3, 32'h2000, 32'h2100, 5'b10101);
    next_cycle();
    // Main memory without the atomic attribute
    write_region(4, 32'h3000, 32'h3100, 5'b10100);
    next_cycle();
    kinds = '{Q_FETCH, Q_MIS, Q_PP, Q_ATOM};
    for (int k = 0; k < 4; k++) begin
      send(32'h0000_4010, kinds[k]);
      send(32'h0000_8010, kinds[k]);
    end
    send(32'h0000_C010, Q_ATOM);
    send(32'h0000_4020, Q_STORE);
    end_test();
  endtask

  task automatic attribute_derivation();
    begin_test("attribute_derivation");
    write_region(5, 32'h4000, 32'h4100, 5'b11010);
    next_cycle();
    write_region(6, 32'h5000, 32'h5100, 5'b11101);
    next_cycle();
    for (int r = 0; r < 2; r++) begin
      send(32'h0001_0040 + r * 32'h4000, Q_STORE);
      send(32'h0001_0040 + r * 32'h4000, Q_LOAD);
      send(32'h0001_0040 + r * 32'h4000, Q_FETCH);
    end
    end_test();
  endtask

  task automatic debug_override();
    logic [5:0] kinds [5];
    begin_test("debug_override");
    // Region 2 is I/O, debug turns it into bare main memory
    kinds = '{Q_FETCH, Q_STORE, Q_LOAD, Q_MIS, Q_PP};
    for (int k = 0; k < 5; k++) begin
      send(32'h0000_4040, kinds[k] | Q_DBG);
    end
    // Bufferable and cacheable region loses both
    send(32'h0001_4020, Q_STORE | Q_DBG);
    // Integrity region loses integrity
    send(32'h0001_0020, Q_STORE | Q_DBG);
    send(32'h0000_8020, Q_ATOM | Q_DBG);
    end_test();
  endtask

  task automatic back_to_back_stream();
    logic [31:0] r;
    logic [31:0] low;
    logic [5:0]  q;
    begin_test("back_to_back_stream");
    for (int i = 0; i < STREAM_REQS; i++) begin
      r    = rand32();
      q    = r[5:0];
      // Debug region on roughly one request in eight
      q[5] = (r[8:6] == 3'b000);
      drive_request(rand32() % 32'h18000, q);
      // Same-cycle write, the request above still sees the old entry
      if (i % 8 == 3) begin
        r   = rand32();
        low = rand32() % 32'h6000;
        write_region(int'(r % `PMA_NUM_REGIONS), low, low + (rand32() % 32'h800), r[12:8]);
      end
      next_cycle();
    end
    end_test();
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    rst_i = 1'b1;
    {cfg_we_i, cfg_main_i, cfg_bufferable_i, cfg_cacheable_i, cfg_integrity_i} = '0;
    cfg_atomic_i    = 1'b0;
    cfg_idx_i       = '0;
    cfg_addr_low_i  = '0;
    cfg_addr_high_i = '0;
    {trans_valid_i, trans_debug_region_i, trans_pushpop_i, instr_fetch_access_i} = '0;
    {misaligned_access_i, load_access_i, atomic_access_i} = '0;
    trans_id_i   = '0;
    trans_addr_i = '0;
    rng_state    = 32'd71;
    next_id      = '0;
    err_cnt      = 0;
    check_cnt    = 0;
    cur_test     = "reset";
    for (int i = 0; i < `PMA_NUM_REGIONS; i++) begin
      mirror[i] = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    reset_defaults();
    region_priority();
    access_rules();
    attribute_derivation();
    debug_override();
    back_to_back_stream();
    $display("Results checked %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== tb_pma_unit_assertions.sv ====
`timescale 1ns/1ps

module tb_pma_unit_assertions (
  input logic clk,
  input logic rst_i,
  input logic trans_valid_i,
  // Qualifiers as registered into the check stage
  input logic lk_valid_i,
  input logic lk_fetch_i,
  input logic lk_load_i,
  input logic pma_valid_i,
  input logic pma_bufferable_i
);

  // Fixed two-stage latency, the pipeline never stalls
  a_valid_latency: assert property (
    @(posedge clk) disable iff (rst_i) pma_valid_i == $past(trans_valid_i, 2)
  ) else $error("result valid does not follow the request valid by two cycles");

  // Fetches and loads never come back bufferable
  a_no_buf_fetch_load: assert property (
    @(posedge clk) disable iff (rst_i)
      lk_valid_i && (lk_fetch_i || lk_load_i) |=> !pma_valid_i || !pma_bufferable_i
  ) else $error("bufferable reported for a fetch or load");

  // Output stays quiet while reset is held
  a_quiet_in_reset: assert property (
    @(posedge clk) rst_i && $past(rst_i) |-> !pma_valid_i
  ) else $error("result valid seen while reset is held");

endmodule

bind pma_unit tb_pma_unit_assertions u_assertions (
  .clk              (clk),
  .rst_i            (rst_i),
  .trans_valid_i    (trans_valid_i),
  .lk_valid_i       (lk_valid),
  .lk_fetch_i       (lk_fetch),
  .lk_load_i        (lk_load),
  .pma_valid_i      (pma_valid_o),
  .pma_bufferable_i (pma_bufferable_o)
);

// ==== pma_unit.sv ====
`timescale 1ns/1ps

`include "pma_defs.svh"

module pma_unit (
  input  logic                    clk,
  input  logic                    rst_i,

  // Region table write
  input  logic                    cfg_we_i,
  input  pma_pkg::pma_idx_t       cfg_idx_i,
  input  logic [31:0]             cfg_addr_low_i,
  input  logic [31:0]             cfg_addr_high_i,
  input  logic                    cfg_main_i,
  input  logic                    cfg_bufferable_i,
  input  logic                    cfg_cacheable_i,
  input  logic                    cfg_integrity_i,
  input  logic                    cfg_atomic_i,

  // Transaction request
  input  logic                    trans_valid_i,
  input  logic [`PMA_ID_W-1:0]    trans_id_i,
  input  logic [31:0]             trans_addr_i,
  input  logic                    trans_debug_region_i,
  input  logic                    trans_pushpop_i,
  input  logic                    instr_fetch_access_i,
  input  logic                    misaligned_access_i,
  input  logic                    load_access_i,
  input  logic                    atomic_access_i,

  // Result, two cycles after the request
  output logic                    pma_valid_o,
  output logic [`PMA_ID_W-1:0]    pma_id_o,
  output logic                    pma_err_o,
  output logic                    pma_integrity_o,
  output logic                    pma_bufferable_o,
  output logic                    pma_cacheable_o
);

  pma_pkg::pma_cfg_t [`PMA_NUM_REGIONS-1:0] region_cfg;

  // Stage 1 to stage 2
  logic                 lk_valid;
  logic [`PMA_ID_W-1:0] lk_id;
  pma_pkg::pma_cfg_t    lk_cfg;
  logic                 lk_fetch;
  logic                 lk_load;
  logic                 lk_misaligned;
  logic                 lk_pushpop;
  logic                 lk_atomic;

  //////////////////////////////////////////////////
  // Region table
  //////////////////////////////////////////////////

  pma_region_table u_region_table (
    .clk              (clk),
    .rst_i            (rst_i),
    .cfg_we_i         (cfg_we_i),
    .cfg_idx_i        (cfg_idx_i),
    .cfg_addr_low_i   (cfg_addr_low_i),
    .cfg_addr_high_i  (cfg_addr_high_i),
    .cfg_main_i       (cfg_main_i),
    .cfg_bufferable_i (cfg_bufferable_i),
    .cfg_cacheable_i  (cfg_cacheable_i),
    .cfg_integrity_i  (cfg_integrity_i),
    .cfg_atomic_i     (cfg_atomic_i),
    .region_cfg_o     (region_cfg)
  );

  //////////////////////////////////////////////////
  // Pipeline stages
  //////////////////////////////////////////////////

  // Stage 1 resolves the region
  pma_lookup_stage u_lookup (
    .clk                  (clk),
    .rst_i                (rst_i),
    .region_cfg_i         (region_cfg),
    .trans_valid_i        (trans_valid_i),
    .trans_id_i           (trans_id_i),
    .trans_addr_i         (trans_addr_i),
    .trans_debug_region_i (trans_debug_region_i),
    .trans_pushpop_i      (trans_pushpop_i),
    .instr_fetch_access_i (instr_fetch_access_i),
    .misaligned_access_i  (misaligned_access_i),
    .load_access_i        (load_access_i),
    .atomic_access_i      (atomic_access_i),
    .lk_valid_o           (lk_valid),
    .lk_id_o              (lk_id),
    .lk_cfg_o             (lk_cfg),
    .lk_fetch_o           (lk_fetch),
    .lk_load_o            (lk_load),
    .lk_misaligned_o      (lk_misaligned),
    .lk_pushpop_o         (lk_pushpop),
    .lk_atomic_o          (lk_atomic)
  );

  // Stage 2 applies the access rules
  pma_check_stage u_check (
    .clk              (clk),
    .rst_i            (rst_i),
    .lk_valid_i       (lk_valid),
    .lk_id_i          (lk_id),
    .lk_cfg_i         (lk_cfg),
    .lk_fetch_i       (lk_fetch),
    .lk_load_i        (lk_load),
    .lk_misaligned_i  (lk_misaligned),
    .lk_pushpop_i     (lk_pushpop),
    .lk_atomic_i      (lk_atomic),
    .pma_valid_o      (pma_valid_o),
    .pma_id_o         (pma_id_o),
    .pma_err_o        (pma_err_o),
    .pma_integrity_o  (pma_integrity_o),
    .pma_bufferable_o (pma_bufferable_o),
    .pma_cacheable_o  (pma_cacheable_o)
  );

endmodule

// ==== pma_check_stage.sv ====
`timescale 1ns/1ps

`include "pma_defs.svh"

module pma_check_stage (
  input  logic                    clk,
  input  logic                    rst_i,

  // Lookup stage result
  input  logic                    lk_valid_i,
  input  logic [`PMA_ID_W-1:0]    lk_id_i,
  input  pma_pkg::pma_cfg_t       lk_cfg_i,
  input  logic                    lk_fetch_i,
  input  logic                    lk_load_i,
  input  logic                    lk_misaligned_i,
  input  logic                    lk_pushpop_i,
  input  logic                    lk_atomic_i,

  // Final PMA result
  output logic                    pma_valid_o,
  output logic [`PMA_ID_W-1:0]    pma_id_o,
  output logic                    pma_err_o,
  output logic                    pma_integrity_o,
  output logic                    pma_bufferable_o,
  output logic                    pma_cacheable_o
);

  logic main_err;
  logic atomic_err;
  logic access_err;
  logic bufferable;

  //////////////////////////////////////////////////
  // Access rules
  //////////////////////////////////////////////////

  // Fetch, misaligned and push/pop all need main memory
  assign main_err = (lk_fetch_i || lk_misaligned_i || lk_pushpop_i) && !lk_cfg_i.main;

  // Atomics need the region atomic attribute
  // Only checked when the atomic extension is built in
  assign atomic_err = (`PMA_A_EXT != 0) && lk_atomic_i && !lk_cfg_i.atomic;

  assign access_err = main_err || atomic_err;

  // Fetches and loads are never bufferable
  assign bufferable = lk_cfg_i.bufferable && !lk_fetch_i && !lk_load_i;

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pma_valid_o      <= 1'b0;
      pma_id_o         <= '0;
      pma_err_o        <= 1'b0;
      pma_integrity_o  <= 1'b0;
      pma_bufferable_o <= 1'b0;
      pma_cacheable_o  <= 1'b0;
    end else begin
      pma_valid_o <= lk_valid_i;
      // Result fields hold between valid pulses
      if (lk_valid_i) begin
        pma_id_o         <= lk_id_i;
        pma_err_o        <= access_err;
        pma_integrity_o  <= lk_cfg_i.integrity;
        pma_bufferable_o <= bufferable;
        pma_cacheable_o  <= lk_cfg_i.cacheable;
      end
    end
  end

endmodule

// ==== pma_lookup_stage.sv ====
`timescale 1ns/1ps

`include "pma_defs.svh"

module pma_lookup_stage (
  input  logic                                        clk,
  input  logic                                        rst_i,

  // Region table contents
  input  pma_pkg::pma_cfg_t [`PMA_NUM_REGIONS-1:0]    region_cfg_i,

  // Transaction request
  input  logic                                        trans_valid_i,
  input  logic [`PMA_ID_W-1:0]                        trans_id_i,
  input  logic [31:0]                                 trans_addr_i,
  input  logic                                        trans_debug_region_i,
  input  logic                                        trans_pushpop_i,
  input  logic                                        instr_fetch_access_i,
  input  logic                                        misaligned_access_i,
  input  logic                                        load_access_i,
  input  logic                                        atomic_access_i,

  // Registered lookup result towards the check stage
  output logic                                        lk_valid_o,
  output logic [`PMA_ID_W-1:0]                        lk_id_o,
  output pma_pkg::pma_cfg_t                           lk_cfg_o,
  output logic                                        lk_fetch_o,
  output logic                                        lk_load_o,
  output logic                                        lk_misaligned_o,
  output logic                                        lk_pushpop_o,
  output logic                                        lk_atomic_o
);

  logic [31:0]                 word_addr;
  logic [`PMA_NUM_REGIONS-1:0] region_hit;
  logic                        hit_found;
  pma_pkg::pma_cfg_t           match_cfg;
  pma_pkg::pma_cfg_t           resolved_cfg;

  //////////////////////////////////////////////////
  // Region match
  //////////////////////////////////////////////////

  // Table bounds are word addresses
  assign word_addr = {2'b00, trans_addr_i[31:2]};

  // Range compare for every region in parallel
  generate
    for (genvar i = 0; i < `PMA_NUM_REGIONS; i++) begin : g_cmp
      assign region_hit[i] = (word_addr >= region_cfg_i[i].word_addr_low) &&
                             (word_addr <  region_cfg_i[i].word_addr_high);
    end
  endgenerate

  // Priority select
  // Lowest index wins when ranges overlap
  always_comb begin
    hit_found = 1'b0;
    match_cfg = pma_pkg::PMA_R_DEFAULT;
    for (int i = 0; i < `PMA_NUM_REGIONS; i++) begin
      if (region_hit[i] && !hit_found) begin
        hit_found = 1'b1;
        match_cfg = region_cfg_i[i];
      end
    end
  end

  // Debug module region overrides any table match
  assign resolved_cfg = trans_debug_region_i ? pma_pkg::PMA_DBG : match_cfg;

  //////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      lk_valid_o <= 1'b0;
    end else begin
      lk_valid_o <= trans_valid_i;
    end
  end

  // Payload only loads with a valid request
  always_ff @(posedge clk) begin
    if (trans_valid_i) begin
      lk_id_o         <= trans_id_i;
      lk_cfg_o        <= resolved_cfg;
      lk_fetch_o      <= instr_fetch_access_i;
      lk_load_o       <= load_access_i;
      lk_misaligned_o <= misaligned_access_i;
      lk_pushpop_o    <= trans_pushpop_i;
      lk_atomic_o     <= atomic_access_i;
    end
  end

endmodule

// ==== pma_region_table.sv ====
`timescale 1ns/1ps

`include "pma_defs.svh"

module pma_region_table (
  input  logic                                        clk,
  input  logic                                        rst_i,

  // Configuration write port
  input  logic                                        cfg_we_i,
  input  pma_pkg::pma_idx_t                           cfg_idx_i,
  input  logic [31:0]                                 cfg_addr_low_i,
  input  logic [31:0]                                 cfg_addr_high_i,
  input  logic                                        cfg_main_i,
  input  logic                                        cfg_bufferable_i,
  input  logic                                        cfg_cacheable_i,
  input  logic                                        cfg_integrity_i,
  input  logic                                        cfg_atomic_i,

  // All regions, read combinationally by the lookup stage
  output pma_pkg::pma_cfg_t [`PMA_NUM_REGIONS-1:0]    region_cfg_o
);

  //////////////////////////////////////////////////
  // Write data
  //////////////////////////////////////////////////

  pma_pkg::pma_cfg_t                        wr_cfg;
  logic [`PMA_NUM_REGIONS-1:0]              entry_we;
  pma_pkg::pma_cfg_t [`PMA_NUM_REGIONS-1:0] region_q;

  // Pack the loose write fields into one configuration word
  always_comb begin
    wr_cfg                = pma_pkg::PMA_R_DEFAULT;
    wr_cfg.word_addr_low  = cfg_addr_low_i;
    wr_cfg.word_addr_high = cfg_addr_high_i;
    wr_cfg.main           = cfg_main_i;
    wr_cfg.bufferable     = cfg_bufferable_i;
    wr_cfg.cacheable      = cfg_cacheable_i;
    wr_cfg.integrity      = cfg_integrity_i;
    wr_cfg.atomic         = cfg_atomic_i;
  end

  //////////////////////////////////////////////////
  // Region registers
  //////////////////////////////////////////////////

  generate
    for (genvar i = 0; i < `PMA_NUM_REGIONS; i++) begin : g_entry

      // Per-entry write decode
      // An index beyond the table selects no entry and the write is dropped
      assign entry_we[i] = cfg_we_i && (cfg_idx_i == i);

      // Reset leaves every entry with an empty range, so nothing matches
      always_ff @(posedge clk) begin
        if (rst_i) begin
          region_q[i] <= pma_pkg::PMA_R_DEFAULT;
        end else if (entry_we[i]) begin
          region_q[i] <= wr_cfg;
        end
      end

    end
  endgenerate

  // New contents become visible the cycle after the strobe
  // A request sampled on the same edge still sees the old entry
  assign region_cfg_o = region_q;

endmodule

// ==== pma_pkg.sv ====
`include "pma_defs.svh"

package pma_pkg;

  //////////////////////////////////////////////////
  // Region index
  //////////////////////////////////////////////////

  // At least one bit even for a single-region table
  localparam int PMA_IDX_W = (`PMA_NUM_REGIONS > 1) ? $clog2(`PMA_NUM_REGIONS) : 1;

  typedef logic [PMA_IDX_W-1:0] pma_idx_t;

  //////////////////////////////////////////////////
  // Region configuration
  //////////////////////////////////////////////////

  // Region range is in word addresses
  // Low bound inclusive, high bound exclusive
  typedef struct packed {
    logic [31:0] word_addr_low;
    logic [31:0] word_addr_high;
    // Main memory, otherwise I/O
    logic        main;
    logic        bufferable;
    logic        cacheable;
    // Integrity checking enabled for this region
    logic        integrity;
    // Atomic operations permitted
    logic        atomic;
  } pma_cfg_t;

  // Attributes when no region matches
  // All zero, so the access is treated as I/O
  localparam pma_cfg_t PMA_R_DEFAULT = '{
    word_addr_low  : 32'h0,
    word_addr_high : 32'h0,
    main           : 1'b0,
    bufferable     : 1'b0,
    cacheable      : 1'b0,
    integrity      : 1'b0,
    atomic         : 1'b0
  };

  // Attributes forced for debug module region accesses
  // Range fields are don't care here
  localparam pma_cfg_t PMA_DBG = '{
    word_addr_low  : 32'h0,
    word_addr_high : 32'h0,
    main           : 1'b1,
    bufferable     : 1'b0,
    cacheable      : 1'b0,
    integrity      : 1'b0,
    atomic         : 1'b0
  };

endpackage

// ==== pma_defs.svh ====
`ifndef PMA_DEFS_SVH
`define PMA_DEFS_SVH

//////////////////////////////////////////////////
// PMA build-time configuration
//////////////////////////////////////////////////

// Number of programmable regions in the table
// Any value from 1 up is supported
`define PMA_NUM_REGIONS 8

// Width of the transaction ID tag carried through the pipeline
`define PMA_ID_W 4

// Atomic extension present
// 1 checks atomic accesses against the region atomic attribute
// 0 lets atomic accesses through on any region
`define PMA_A_EXT 1

`endif
